// File: bmd_dma_top.f
design/bmd_pkg.sv
design/dma_cfg_if.sv
design/dma_fifo.sv
design/dma_ctrl_regs.sv
design/adc_sample_packer.sv
design/mwr_tx_engine.sv
design/bmd_dma_top.sv
dv/tb_bmd_dma.sv

// File: Makefile
# Verilator build and run of the DMA write path testbench
LOG := sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench, check $(LOG)"
	@echo "  clean  remove obj_dir and $(LOG)"
	@echo "  help   show this list"

test:
	verilator --binary --timing --assert --timescale 1ns/1ps \
		--top-module tb_bmd_dma -f bmd_dma_top.f -o sim_tb_bmd_dma
	./obj_dir/sim_tb_bmd_dma > $(LOG) 2>&1; cat $(LOG)
	grep -q "All tests passed" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

// File: dv/tb_bmd_dma.sv
// DMA write path testbench
`timescale 1ns/1ps
`default_nettype none

module tb_bmd_dma;
    import bmd_pkg::*;

    localparam int          DATA_DEPTH     = 32;
    localparam int          TIMEOUT_CYCLES = 20000;    // Whole run is under 2000 cycles
    localparam logic [15:0] COMPLETER_ID   = 16'h01A5;

    logic        clk;
    logic        rst_n;
    logic        reg_wr;
    logic [3:0]  reg_addr;
    logic [31:0] reg_wdata;
    logic        adc_valid;
    logic [7:0]  adc1;
    logic [7:0]  adc2;
    logic        dst_rdy_n;
    payload_t    trn_td;
    logic        tsof_n;
    logic        teof_n;
    logic        tsrc_rdy_n;
    logic [15:0] frames_sent;
    logic        sample_ovf;
    logic        addr_empty;

    payload_t    exp_words[$];      // Packed words still owed on the stream
    dma_addr_t   exp_addrs[$];      // Queued host buffer addresses
    payload_t    model_word;
    int          pair_cnt;
    logic        model_en;
    int          exp_len;
    logic [2:0]  exp_tc;
    logic [7:0]  exp_tag;

    string       test_name;
    logic        bp_on;
    int          beat_idx;
    int          frames_checked;
    int          total_frames;
    int          cycle_cnt;
    int          value_errs;
    int          stream_errs;
    int          other_errs;

    bmd_dma_top #(.DATA_DEPTH(DATA_DEPTH), .ADDR_DEPTH(8)) i_bmd_dma_top (
        .clk (clk), .rst_n (rst_n),
        .reg_wr_i (reg_wr), .reg_addr_i (reg_addr), .reg_wdata_i (reg_wdata),
        .adc_valid_i (adc_valid), .adc1_i (adc1), .adc2_i (adc2),
        .cfg_completer_id_i (COMPLETER_ID), .trn_tdst_rdy_n_i (dst_rdy_n),
        .trn_td_o (trn_td), .trn_tsof_n_o (tsof_n), .trn_teof_n_o (teof_n),
        .trn_tsrc_rdy_n_o (tsrc_rdy_n), .frames_sent_o (frames_sent),
        .sample_ovf_o (sample_ovf), .addr_empty_o (addr_empty)
    );

    always #10 clk = ~clk;

    // Sink stalls about one cycle in three
    always @(posedge clk) begin
        #1;
        dst_rdy_n = bp_on ? ($urandom % 3 == 0) : 1'b0;
    end

    // ------------------------------------------------------------------
    // Stream properties
    // ------------------------------------------------------------------
    beat_hold_a : assert property (@(posedge clk) disable iff (!rst_n)
        (!tsrc_rdy_n && dst_rdy_n) |=> ($stable(trn_td) && $stable(tsof_n) && $stable(teof_n)))
        else begin
            stream_errs++;
            $display("In %s a stalled beat changed before the sink took it", test_name);
        end

    idle_without_addr_a : assert property (@(posedge clk) disable iff (!rst_n)
        addr_empty |-> tsrc_rdy_n)
        else begin
            stream_errs++;
            $display("In %s the engine sent a beat with no address queued", test_name);
        end

    ovf_sticky_a : assert property (@(posedge clk) disable iff (!rst_n)
        sample_ovf |=> sample_ovf)
        else begin
            stream_errs++;
            $display("In %s the overflow flag dropped without a reset", test_name);
        end

    task automatic check_eq(input string what, input logic [63:0] exp, input logic [63:0] act);
        assert (act === exp) else begin
            value_errs++;
            $display("Error %s: %s expected 0x%0h, actual 0x%0h", test_name, what, exp, act);
        end
    endtask

    task automatic report_counts();
        $display("Frames checked %0d, value errors %0d, stream errors %0d, other errors %0d",
                 total_frames, value_errs, stream_errs, other_errs);
    endtask

    // ------------------------------------------------------------------
    // Reference model and stimulus
    // ------------------------------------------------------------------
    task automatic model_pair(input logic [7:0] a1, input logic [7:0] a2);
        model_word[pair_cnt*16 +: 16] = {a2, a1};           // adc1 in the low byte
        if (pair_cnt == 3) begin
            pair_cnt = 0;
            if (exp_words.size() < DATA_DEPTH) begin
                exp_words.push_back(model_word);
            end
        end else begin
            pair_cnt++;
        end
    endtask

    task automatic write_reg(input logic [3:0] addr, input logic [31:0] data);
        reg_wr    = 1'b1;
        reg_addr  = addr;
        reg_wdata = data;
        @(posedge clk);
        #1;
        reg_wr = 1'b0;
        if (addr == REG_CTRL) begin
            model_en = data[0];
            exp_tc   = data[6:4];
            if (!data[0]) begin
                pair_cnt = 0;
            end
        end
        if (addr == REG_LEN) begin
            exp_len = (data[3:0] == 4'd0) ? 16 : int'(data[3:0]);
        end
        if (addr == REG_ADDR) begin
            exp_addrs.push_back(data);
        end
    endtask

    task automatic send_samples(input int n);
        logic [7:0] a1;
        logic [7:0] a2;
        for (int i = 0; i < n; i++) begin
            a1        = 8'($urandom);
            a2        = 8'($urandom);
            adc_valid = 1'b1;
            adc1      = a1;
            adc2      = a2;
            if (model_en) begin
                model_pair(a1, a2);
            end
            @(posedge clk);
            #1;
            adc_valid = 1'b0;
            if ($urandom % 4 == 0) begin                    // Occasional idle cycle
                @(posedge clk);
                #1;
            end
        end
    endtask

    task automatic check_reset_state();
        check_eq("tsrc_rdy_n after reset", 64'(1), 64'(tsrc_rdy_n));
        check_eq("tsof_n after reset", 64'(1), 64'(tsof_n));
        check_eq("teof_n after reset", 64'(1), 64'(teof_n));
        check_eq("frames_sent_o after reset", 64'(0), 64'(frames_sent));
        check_eq("sample_ovf_o after reset", 64'(0), 64'(sample_ovf));
        check_eq("addr_empty_o after reset", 64'(1), 64'(addr_empty));
    endtask

    task automatic apply_reset();
        rst_n = 1'b0;
        repeat (10) @(posedge clk);
        #1;
        rst_n = 1'b1;
        exp_words.delete();
        exp_addrs.delete();
        model_en       = 1'b0;
        pair_cnt       = 0;
        exp_len        = 1;
        exp_tc         = 3'd0;
        exp_tag        = 8'd0;
        frames_checked = 0;
        check_reset_state();
    endtask

    task automatic wait_frames(input int n);
        while (frames_checked < n) begin
            @(posedge clk);
            #1;
        end
        check_eq("words left in model", 64'(0), 64'(exp_words.size()));
        check_eq("addresses left in model", 64'(0), 64'(exp_addrs.size()));
    endtask

    // ------------------------------------------------------------------
    // Frame checker
    // ------------------------------------------------------------------
    task automatic check_beat();
        logic [9:0]  len_dw;
        logic [31:0] hdr_hi;
        logic [31:0] hdr_lo;
        dma_addr_t   addr;
        len_dw = 10'(2 * exp_len);                          // Two DW per beat
        hdr_hi = {1'b0, MWR32_FMT_TYPE, 1'b0, exp_tc, 4'h0, 6'h00, len_dw};
        hdr_lo = {COMPLETER_ID, exp_tag, 8'hFF};
        check_eq("tsof_n", 64'(beat_idx != 0), 64'(tsof_n));
        check_eq("teof_n", 64'(beat_idx != exp_len + 1), 64'(teof_n));
        if (beat_idx == 0) begin
            check_eq("header beat", {hdr_hi, hdr_lo}, trn_td);
        end else if (beat_idx == 1) begin
            if (exp_addrs.size() == 0) begin
                other_errs++;
                $display("In %s a frame started with no address queued", test_name);
            end else begin
                addr = exp_addrs.pop_front();
                check_eq("address beat", {addr, 32'h0}, trn_td);
            end
        end else if (exp_words.size() == 0) begin
            other_errs++;
            $display("In %s a frame carried a payload beat that was never sent", test_name);
        end else begin
            check_eq("payload beat", exp_words.pop_front(), trn_td);
        end
        if (beat_idx == exp_len + 1) begin
            check_eq("frames_sent_o", 64'(frames_checked), 64'(frames_sent));
            frames_checked++;
            total_frames++;
            exp_tag++;
            beat_idx = 0;
        end else begin
            beat_idx++;
        end
    endtask

    // Mid-cycle sampling, all lines settled
    always @(negedge clk) begin
        if (!rst_n) begin
            beat_idx = 0;
        end else if (!tsrc_rdy_n && !dst_rdy_n) begin
            check_beat();
        end
    end

    initial begin
        cycle_cnt = 0;
        while (cycle_cnt < TIMEOUT_CYCLES) begin
            @(posedge clk);
            cycle_cnt++;
        end
        $display("Run stopped after %0d cycles while waiting for a frame", cycle_cnt);
        report_counts();
        $display("Some tests failed");
        $finish;
    end

    // ------------------------------------------------------------------
    // Test sequence
    // ------------------------------------------------------------------
    initial begin
        void'($urandom(62));
        clk          = 1'b0;
        rst_n        = 1'b0;
        reg_wr       = 1'b0;
        reg_addr     = 4'd0;
        reg_wdata    = 32'd0;
        adc_valid    = 1'b0;
        adc1         = 8'd0;
        adc2         = 8'd0;
        dst_rdy_n    = 1'b0;
        bp_on        = 1'b0;
        total_frames = 0;
        value_errs   = 0;
        stream_errs  = 0;
        other_errs   = 0;

        test_name = "reset_state";
        apply_reset();

        test_name = "single_frame";
        send_samples(4);                                    // Dropped, DMA still off
        write_reg(REG_CTRL, 32'h31);
        write_reg(REG_LEN, 32'd2);
        write_reg(REG_ADDR, 32'h8000_1000);
        send_samples(8);
        wait_frames(1);

        test_name = "back_pressure";
        apply_reset();
        bp_on = 1'b1;
        write_reg(REG_CTRL, 32'h21);
        write_reg(REG_LEN, 32'd4);
        write_reg(REG_ADDR, 32'h8000_2000);
        write_reg(REG_ADDR, 32'h8000_2400);
        send_samples(32);
        wait_frames(2);
        bp_on = 1'b0;

        test_name = "address_order";
        apply_reset();
        write_reg(REG_CTRL, 32'h71);
        write_reg(REG_LEN, 32'd2);
        write_reg(REG_ADDR, 32'h1000_0000);
        write_reg(REG_ADDR, 32'h1000_0100);
        write_reg(REG_ADDR, 32'h1000_0200);
        send_samples(24);
        wait_frames(3);
        repeat (2) @(posedge clk);
        #1;
        check_eq("frames_sent_o total", 64'(3), 64'(frames_sent));

        test_name = "no_address";
        apply_reset();
        write_reg(REG_CTRL, 32'h51);
        write_reg(REG_LEN, 32'd2);
        send_samples(8);
        repeat (40) begin
            @(posedge clk);
            #1;
            check_eq("tsrc_rdy_n without address", 64'(1), 64'(tsrc_rdy_n));
            check_eq("addr_empty_o without address", 64'(1), 64'(addr_empty));
        end
        write_reg(REG_ADDR, 32'h8000_3000);                 // Buffered words go out now
        wait_frames(1);

        test_name = "overflow";
        apply_reset();
        write_reg(REG_CTRL, 32'h11);
        send_samples(4 * (DATA_DEPTH + 4));
        repeat (3) @(posedge clk);
        #1;
        check_eq("sample_ovf_o after overrun", 64'(1), 64'(sample_ovf));
        write_reg(REG_LEN, 32'd0);                          // Zero selects 16 beats
        write_reg(REG_ADDR, 32'h8000_4000);
        write_reg(REG_ADDR, 32'h8000_5000);
        wait_frames(2);
        check_eq("sample_ovf_o after drain", 64'(1), 64'(sample_ovf));

        report_counts();
        if (value_errs + stream_errs + other_errs == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

endmodule : tb_bmd_dma

`default_nettype wire

// File: design/bmd_dma_top.sv
// Bus-master DMA write path
`timescale 1ns/1ps
`default_nettype none

module bmd_dma_top #(
    parameter int DATA_DEPTH = 32,
    parameter int ADDR_DEPTH = 8
) (
    input  wire logic                          clk,
    input  wire logic                          rst_n,
    // Host register port
    input  wire logic                          reg_wr_i,
    input  wire logic [3:0]                    reg_addr_i,
    input  wire logic [31:0]                   reg_wdata_i,
    // ADC samples
    input  wire logic                          adc_valid_i,
    input  wire logic [bmd_pkg::SAMPLE_W-1:0]  adc1_i,
    input  wire logic [bmd_pkg::SAMPLE_W-1:0]  adc2_i,
    input  wire logic [15:0]                   cfg_completer_id_i,
    // Transmit stream
    input  wire logic                          trn_tdst_rdy_n_i,
    output      bmd_pkg::payload_t             trn_td_o,
    output      logic                          trn_tsof_n_o,
    output      logic                          trn_teof_n_o,
    output      logic                          trn_tsrc_rdy_n_o,
    // Status
    output      logic [15:0]                   frames_sent_o,
    output      logic                          sample_ovf_o,
    output      logic                          addr_empty_o
);
    import bmd_pkg::*;

    logic                            addr_push;
    dma_addr_t                       addr_data;
    dma_addr_t                       addr_head;
    logic                            addr_pop;
    logic                            data_push;
    payload_t                        data_word;
    logic                            data_full;
    payload_t                        data_head;
    logic [$clog2(DATA_DEPTH+1)-1:0] data_count;
    logic                            data_pop;

    dma_cfg_if cfg_if ();

    dma_ctrl_regs i_dma_ctrl_regs (
        .clk           (clk),
        .rst_n         (rst_n),
        .reg_wr_i      (reg_wr_i),
        .reg_addr_i    (reg_addr_i),
        .reg_wdata_i   (reg_wdata_i),
        .addr_push_o   (addr_push),
        .addr_data_o   (addr_data),
        .frames_sent_o (frames_sent_o),
        .cfg           (cfg_if.regs)
    );

    adc_sample_packer i_adc_sample_packer (
        .clk         (clk),
        .rst_n       (rst_n),
        .enable_i    (cfg_if.enable),
        .adc_valid_i (adc_valid_i),
        .adc1_i      (adc1_i),
        .adc2_i      (adc2_i),
        .full_i      (data_full),
        .push_o      (data_push),
        .word_o      (data_word),
        .ovf_o       (sample_ovf_o)
    );

    // Payload buffer
    dma_fifo #(.DEPTH(DATA_DEPTH), .T(payload_t)) i_data_fifo (
        .clk (clk), .rst_n (rst_n),
        .push_i (data_push), .data_i (data_word), .pop_i (data_pop),
        .head_o (data_head), .full_o (data_full), .empty_o (), .count_o (data_count)
    );

    // Host buffer address queue
    dma_fifo #(.DEPTH(ADDR_DEPTH), .T(dma_addr_t)) i_addr_fifo (
        .clk (clk), .rst_n (rst_n),
        .push_i (addr_push), .data_i (addr_data), .pop_i (addr_pop),
        .head_o (addr_head), .full_o (), .empty_o (addr_empty_o), .count_o ()
    );

    mwr_tx_engine #(.DATA_DEPTH(DATA_DEPTH)) i_mwr_tx_engine (
        .clk                (clk),
        .rst_n              (rst_n),
        .cfg_completer_id_i (cfg_completer_id_i),
        .data_head_i        (data_head),
        .data_count_i       (data_count),
        .data_pop_o         (data_pop),
        .addr_head_i        (addr_head),
        .addr_empty_i       (addr_empty_o),
        .addr_pop_o         (addr_pop),
        .trn_td_o           (trn_td_o),
        .trn_tsof_n_o       (trn_tsof_n_o),
        .trn_teof_n_o       (trn_teof_n_o),
        .trn_tsrc_rdy_n_o   (trn_tsrc_rdy_n_o),
        .trn_tdst_rdy_n_i   (trn_tdst_rdy_n_i),
        .cfg                (cfg_if.engine)
    );

endmodule : bmd_dma_top

`default_nettype wire

// File: design/mwr_tx_engine.sv
// Memory-write transmit engine
`timescale 1ns/1ps
`default_nettype none

module mwr_tx_engine #(
    parameter int DATA_DEPTH = 32
) (
    input  wire logic                            clk,
    input  wire logic                            rst_n,
    input  wire logic [15:0]                     cfg_completer_id_i,
    // Data FIFO
    input  wire bmd_pkg::payload_t               data_head_i,
    input  wire logic [$clog2(DATA_DEPTH+1)-1:0] data_count_i,
    output      logic                            data_pop_o,
    // Address FIFO
    input  wire bmd_pkg::dma_addr_t              addr_head_i,
    input  wire logic                            addr_empty_i,
    output      logic                            addr_pop_o,
    // Transmit stream
    output      bmd_pkg::payload_t               trn_td_o,
    output      logic                            trn_tsof_n_o,
    output      logic                            trn_teof_n_o,
    output      logic                            trn_tsrc_rdy_n_o,
    input  wire logic                            trn_tdst_rdy_n_i,
    dma_cfg_if.engine                            cfg
);
    import bmd_pkg::*;

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_HEADER,
        ST_ADDR,
        ST_PAYLOAD
    } state_t;

    state_t           state_q;
    burst_len_t       len_q;        // Frame length, fixed at frame start
    logic [TC_W-1:0]  tc_q;
    burst_len_t       rem_q;        // Payload beats left after this one
    logic [7:0]       tag_q;
    logic             start;
    logic             beat_xfer;
    logic             last_beat;
    logic [9:0]       len_dw;
    logic [31:0]      hdr_hi;
    logic [31:0]      hdr_lo;

    assign start     = cfg.enable && !addr_empty_i &&
                       (int'(data_count_i) >= int'(cfg.burst_len));
    assign beat_xfer = !trn_tsrc_rdy_n_o && !trn_tdst_rdy_n_i;
    assign last_beat = (state_q == ST_PAYLOAD) && (rem_q == '0);

    // ------------------------------------------------------------------
    // Header DWs
    // ------------------------------------------------------------------
    assign len_dw = {4'b0000, len_q, 1'b0};            // Two DW per beat
    assign hdr_hi = {1'b0, MWR32_FMT_TYPE, 1'b0, tc_q, 4'b0000, 6'b000000, len_dw};
    assign hdr_lo = {cfg_completer_id_i, tag_q, 8'hFF}; // All byte enables on

    // ------------------------------------------------------------------
    // Frame FSM
    // ------------------------------------------------------------------
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state_q <= ST_IDLE;
            len_q   <= '0;
            tc_q    <= '0;
            rem_q   <= '0;
            tag_q   <= '0;
        end else begin
            case (state_q)
                ST_IDLE: begin
                    if (start) begin
                        len_q   <= cfg.burst_len;
                        tc_q    <= cfg.tc;
                        state_q <= ST_HEADER;
                    end
                end
                ST_HEADER: begin
                    if (beat_xfer) state_q <= ST_ADDR;
                end
                ST_ADDR: begin
                    if (beat_xfer) begin
                        rem_q   <= len_q - burst_len_t'(1);
                        state_q <= ST_PAYLOAD;
                    end
                end
                ST_PAYLOAD: begin
                    if (beat_xfer && last_beat) begin
                        tag_q   <= tag_q + 8'd1;
                        state_q <= ST_IDLE;
                    end else if (beat_xfer) begin
                        rem_q <= rem_q - burst_len_t'(1);
                    end
                end
                default: state_q <= ST_IDLE;
            endcase
        end
    end

    // FIFO heads stay put until popped, so a stalled beat holds
    always_comb begin
        case (state_q)
            ST_HEADER:  trn_td_o = {hdr_hi, hdr_lo};
            ST_ADDR:    trn_td_o = {addr_head_i, {(DATA_W - ADDR_W){1'b0}}};
            ST_PAYLOAD: trn_td_o = data_head_i;
            default:    trn_td_o = '0;
        endcase
    end

    assign trn_tsrc_rdy_n_o = (state_q == ST_IDLE);
    assign trn_tsof_n_o     = (state_q != ST_HEADER);
    assign trn_teof_n_o     = !last_beat;

    assign data_pop_o   = beat_xfer && (state_q == ST_PAYLOAD);
    assign addr_pop_o   = beat_xfer && last_beat;     // Address retires with the frame
    assign cfg.mwr_done = beat_xfer && last_beat;
    assign cfg.busy     = (state_q != ST_IDLE);

endmodule : mwr_tx_engine

`default_nettype wire

// File: design/adc_sample_packer.sv
// ADC sample packer
`timescale 1ns/1ps
`default_nettype none

module adc_sample_packer (
    input  wire logic                          clk,
    input  wire logic                          rst_n,
    input  wire logic                          enable_i,
    input  wire logic                          adc_valid_i,
    input  wire logic [bmd_pkg::SAMPLE_W-1:0]  adc1_i,
    input  wire logic [bmd_pkg::SAMPLE_W-1:0]  adc2_i,
    input  wire logic                          full_i,
    output      logic                          push_o,
    output      bmd_pkg::payload_t             word_o,
    output      logic                          ovf_o
);
    import bmd_pkg::*;

    localparam int PAIR_W = 2 * SAMPLE_W;         // adc2 high, adc1 low
    localparam int PAIRS  = DATA_W / PAIR_W;      // Pairs per payload word
    localparam int CNT_W  = $clog2(PAIRS);

    logic [CNT_W-1:0] pair_cnt_q;
    payload_t         word_q;
    logic             push_q;
    logic             ovf_q;

    // Slot fill, lowest pair first
    always_ff @(posedge clk) begin
        if (enable_i && adc_valid_i) begin
            word_q[pair_cnt_q*PAIR_W +: PAIR_W] <= {adc2_i, adc1_i};
        end
    end

    // ------------------------------------------------------------------
    // Pair count, push and overflow
    // ------------------------------------------------------------------
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            pair_cnt_q <= '0;
            push_q     <= 1'b0;
            ovf_q      <= 1'b0;
        end else begin
            push_q <= 1'b0;
            if (!enable_i) begin
                pair_cnt_q <= '0;                    // Drop a partial word
            end else if (adc_valid_i) begin
                pair_cnt_q <= pair_cnt_q + CNT_W'(1);
                push_q     <= (pair_cnt_q == CNT_W'(PAIRS - 1));
            end
            if (push_q && full_i) begin
                ovf_q <= 1'b1;                       // Sticky until reset
            end
        end
    end

    // Word is lost when the buffer has no room
    assign push_o = push_q && !full_i;
    assign word_o = word_q;
    assign ovf_o  = ovf_q;

endmodule : adc_sample_packer

`default_nettype wire

// File: design/dma_ctrl_regs.sv
// DMA control registers
`timescale 1ns/1ps
`default_nettype none

module dma_ctrl_regs (
    input  wire logic              clk,
    input  wire logic              rst_n,
    input  wire logic              reg_wr_i,
    input  wire logic [3:0]        reg_addr_i,
    input  wire logic [31:0]       reg_wdata_i,
    output      logic              addr_push_o,
    output      bmd_pkg::dma_addr_t addr_data_o,
    output      logic [15:0]       frames_sent_o,
    dma_cfg_if.regs                cfg
);
    import bmd_pkg::*;

    logic             enable_q;
    logic [TC_W-1:0]  tc_q;
    burst_len_t       burst_len_q;
    logic             addr_push_q;
    dma_addr_t        addr_data_q;
    logic [15:0]      frames_q;

    // ------------------------------------------------------------------
    // Register decode
    // ------------------------------------------------------------------
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            enable_q    <= 1'b0;
            tc_q        <= '0;
            burst_len_q <= burst_len_t'(1);     // One beat out of reset
            addr_push_q <= 1'b0;
        end else begin
            addr_push_q <= reg_wr_i && (reg_addr_i == REG_ADDR);
            if (reg_wr_i && (reg_addr_i == REG_CTRL)) begin
                enable_q <= reg_wdata_i[0];
                tc_q     <= reg_wdata_i[TC_W+3:4];
            end
            if (reg_wr_i && (reg_addr_i == REG_LEN)) begin
                // Low nibble of zero selects the full 16 beats
                burst_len_q <= {(reg_wdata_i[3:0] == 4'd0), reg_wdata_i[3:0]};
            end
        end
    end

    // Address word rides along with the push strobe
    always_ff @(posedge clk) begin
        if (reg_wr_i && (reg_addr_i == REG_ADDR)) begin
            addr_data_q <= reg_wdata_i[ADDR_W-1:0];
        end
    end

    // ------------------------------------------------------------------
    // Finished frame counter
    // ------------------------------------------------------------------
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            frames_q <= '0;
        end else if (cfg.mwr_done) begin                // Last beat of a frame
            frames_q <= frames_q + 16'd1;               // Wraps at 16 bits
        end
    end

    assign cfg.enable    = enable_q;
    assign cfg.tc        = tc_q;
    assign cfg.burst_len = burst_len_q;

    assign addr_push_o   = addr_push_q;
    assign addr_data_o   = addr_data_q;
    assign frames_sent_o = frames_q;

endmodule : dma_ctrl_regs

`default_nettype wire

// File: design/dma_fifo.sv
// First-word-fall-through FIFO
`timescale 1ns/1ps
`default_nettype none

module dma_fifo #(
    parameter int  DEPTH = 32,
    parameter type T     = logic [63:0]
) (
    input  wire logic                       clk,
    input  wire logic                       rst_n,
    input  wire logic                       push_i,
    input  wire T                           data_i,
    input  wire logic                       pop_i,
    output      T                           head_o,
    output      logic                       full_o,
    output      logic                       empty_o,
    output      logic [$clog2(DEPTH+1)-1:0] count_o
);

    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_W = $clog2(DEPTH + 1);

    T                 mem_q [DEPTH];
    logic [PTR_W-1:0] wr_ptr_q;
    logic [PTR_W-1:0] rd_ptr_q;
    logic [CNT_W-1:0] count_q;
    logic             push_ok;
    logic             pop_ok;

    function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] ptr);
        if (ptr == PTR_W'(DEPTH - 1)) begin
            return '0;
        end
        return ptr + PTR_W'(1);
    endfunction

    assign push_ok = push_i && !full_o;     // Push while full is ignored
    assign pop_ok  = pop_i && !empty_o;     // Pop while empty is ignored

    always_ff @(posedge clk) begin
        if (push_ok) begin
            mem_q[wr_ptr_q] <= data_i;
        end
    end

    // ------------------------------------------------------------------
    // Pointers and occupancy
    // ------------------------------------------------------------------
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            count_q  <= '0;
        end else begin
            if (push_ok) begin
                wr_ptr_q <= next_ptr(wr_ptr_q);
            end
            if (pop_ok) begin
                rd_ptr_q <= next_ptr(rd_ptr_q);
            end
            case ({push_ok, pop_ok})
                2'b10:   count_q <= count_q + CNT_W'(1);
                2'b01:   count_q <= count_q - CNT_W'(1);
                default: count_q <= count_q;     // Idle or both at once
            endcase
        end
    end

    assign head_o  = mem_q[rd_ptr_q];   // Valid whenever not empty
    assign full_o  = (count_q == CNT_W'(DEPTH));
    assign empty_o = (count_q == '0);
    assign count_o = count_q;

endmodule : dma_fifo

`default_nettype wire

// File: design/dma_cfg_if.sv
// DMA configuration and status link
`timescale 1ns/1ps
`default_nettype none

interface dma_cfg_if;
    import bmd_pkg::*;

    logic             enable;       // DMA run bit
    burst_len_t       burst_len;    // Payload beats per frame
    logic [TC_W-1:0]  tc;           // Traffic class for new frames
    logic             mwr_done;     // Pulse on last beat of a frame
    logic             busy;         // Frame on the stream

    modport regs (
        output enable, burst_len, tc,
        input  mwr_done, busy
    );

    modport engine (
        input  enable, burst_len, tc,
        output mwr_done, busy
    );

endinterface : dma_cfg_if

`default_nettype wire

// File: design/bmd_pkg.sv
// Bus-master DMA shared definitions
`default_nettype none

package bmd_pkg;

    // ------------------------------------------------------------------
    // Widths
    // ------------------------------------------------------------------
    localparam int DATA_W   = 64;           // Stream and payload beat
    localparam int SAMPLE_W = 8;            // One ADC channel
    localparam int ADDR_W   = 32;           // Host buffer address
    localparam int BURST_W  = 5;            // Holds 1 to 16 beats
    localparam int TC_W     = 3;            // Traffic class

    // ------------------------------------------------------------------
    // Types
    // ------------------------------------------------------------------
    typedef logic [DATA_W-1:0]  payload_t;
    typedef logic [ADDR_W-1:0]  dma_addr_t;
    typedef logic [BURST_W-1:0] burst_len_t;

    // ------------------------------------------------------------------
    // Register map
    // ------------------------------------------------------------------
    // Bit 0 enable, bits 6:4 traffic class
    localparam logic [3:0] REG_CTRL = 4'd0;
    // Each write queues one buffer address
    localparam logic [3:0] REG_ADDR = 4'd1;
    // Burst length in beats, 0 means 16
    localparam logic [3:0] REG_LEN  = 4'd2;

    // ------------------------------------------------------------------
    // Frame header
    // ------------------------------------------------------------------
    // fmt 2'b10 (3DW with data), type 5'b00000 (memory request)
    localparam logic [6:0] MWR32_FMT_TYPE = 7'b10_00000;

endpackage : bmd_pkg

`default_nettype wire
